/* verilog/mmu_pkg.sv */
// translation constants for the tlb and mmu
// tlb entry and page record layouts
// exception codes and unmapped segment patterns
package mmu_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;
    localparam int VPN2_W      = 19;   // vaddr[31:13]
    localparam int PFN_W       = 20;
    localparam int ASID_W      = 8;

    localparam logic [2:0] CACHED_C  = 3'd3;     // cacheable noncoherent
    localparam logic [2:0] SEG_KSEG0 = 3'b100;   // unmapped, cached
    localparam logic [2:0] SEG_KSEG1 = 3'b101;   // unmapped, uncached

    typedef struct packed {
        logic [PFN_W-1:0] pfn;
        logic [2:0]       c;
        logic             d;   // page writable
        logic             v;
    } page_info_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        page_info_t        p0;   // even page
        page_info_t        p1;   // odd page
    } tlb_entry_t;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_REFILL   = 2'd1,
        EXC_INVALID  = 2'd2,
        EXC_MODIFIED = 2'd3
    } tlb_exc_e;

endpackage

/* verilog/cp0_regmap_pkg.sv */
// apb offsets of the cp0 registers
// tlb command codes
// cp0 word layout with entryhi and entrylo views
package cp0_regmap_pkg;

    localparam logic [7:0] REG_INDEX    = 8'h00;
    localparam logic [7:0] REG_ENTRYLO0 = 8'h04;
    localparam logic [7:0] REG_ENTRYLO1 = 8'h08;
    localparam logic [7:0] REG_ENTRYHI  = 8'h0C;
    localparam logic [7:0] REG_CMD      = 8'h10;

    localparam logic [31:0] CMD_TLBWI = 32'd1;
    localparam logic [31:0] CMD_TLBP  = 32'd2;

    typedef struct packed {
        logic [18:0] vpn2;   // 31:13
        logic [4:0]  rsvd;
        logic [7:0]  asid;   // 7:0
    } entryhi_t;

    typedef struct packed {
        logic [5:0]  rsvd;
        logic [19:0] pfn;    // 25:6
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entrylo_t;

    typedef union packed {
        entryhi_t hi;
        entrylo_t lo;
    } cp0_word_u;

endpackage

/* verilog/tlb_search_if.sv */
`timescale 1ns/1ps
// one tlb lookup between a requester and the tlb array
// requester drives the key, the array answers combinationally
interface tlb_search_if;

    logic [mmu_pkg::VPN2_W-1:0]    vpn2;
    logic [mmu_pkg::ASID_W-1:0]    asid;
    logic                          odd;    // vaddr[12], page select
    logic                          hit;
    logic [mmu_pkg::TLB_IDX_W-1:0] idx;
    mmu_pkg::page_info_t           page;

    modport requester (
        output vpn2,
        output asid,
        output odd,
        input  hit,
        input  idx,
        input  page
    );

    modport array (
        input  vpn2,
        input  asid,
        input  odd,
        output hit,
        output idx,
        output page
    );

endinterface

/* verilog/tlb_cp0_regs.sv */
`timescale 1ns/1ps
// apb slave for index, entryhi, entrylo0 and entrylo1
// tlbwi entry assembly and write strobe
// tlbp probe through the search bus
module tlb_cp0_regs (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    tlb_search_if.requester               probe,
    output logic                          tlb_we,
    output logic [mmu_pkg::TLB_IDX_W-1:0] tlb_widx,
    output mmu_pkg::tlb_entry_t           tlb_wentry,
    output logic [mmu_pkg::ASID_W-1:0]    asid
);

    logic                          access;
    logic                          offset_ok;
    logic                          cmd_wr;
    logic                          do_tlbp;
    logic                          index_p;     // last probe missed
    logic [mmu_pkg::TLB_IDX_W-1:0] index_idx;
    cp0_regmap_pkg::cp0_word_u     wr_word;
    cp0_regmap_pkg::cp0_word_u     hi_wr;
    cp0_regmap_pkg::cp0_word_u     lo_wr;
    cp0_regmap_pkg::cp0_word_u     entryhi;
    cp0_regmap_pkg::cp0_word_u     entrylo0;
    cp0_regmap_pkg::cp0_word_u     entrylo1;

    assign access  = psel && penable;
    assign cmd_wr  = access && pwrite && (paddr == cp0_regmap_pkg::REG_CMD);
    assign tlb_we  = cmd_wr && (pwdata == cp0_regmap_pkg::CMD_TLBWI);
    assign do_tlbp = cmd_wr && (pwdata == cp0_regmap_pkg::CMD_TLBP);
    assign pready  = 1'b1;
    assign pslverr = access && !offset_ok;

    always_comb begin
        offset_ok = 1'b1;
        prdata    = '0;
        case (paddr)
            cp0_regmap_pkg::REG_INDEX: begin
                prdata = {index_p, {(31 - mmu_pkg::TLB_IDX_W){1'b0}}, index_idx};
            end
            cp0_regmap_pkg::REG_ENTRYLO0: prdata = entrylo0;
            cp0_regmap_pkg::REG_ENTRYLO1: prdata = entrylo1;
            cp0_regmap_pkg::REG_ENTRYHI:  prdata = entryhi;
            cp0_regmap_pkg::REG_CMD:      prdata = '0;   // write-only
            default:                      offset_ok = 1'b0;
        endcase
    end

    // the same write word seen as entryhi or as entrylo
    assign wr_word = pwdata;

    always_comb begin
        hi_wr         = '0;
        hi_wr.hi.vpn2 = wr_word.hi.vpn2;
        hi_wr.hi.asid = wr_word.hi.asid;
        lo_wr         = '0;
        lo_wr.lo.pfn  = wr_word.lo.pfn;
        lo_wr.lo.c    = wr_word.lo.c;
        lo_wr.lo.d    = wr_word.lo.d;
        lo_wr.lo.v    = wr_word.lo.v;
        lo_wr.lo.g    = wr_word.lo.g;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            index_p   <= 1'b0;
            index_idx <= '0;
            entryhi   <= '0;
            entrylo0  <= '0;
            entrylo1  <= '0;
        end else begin
            if (access && pwrite) begin
                case (paddr)
                    cp0_regmap_pkg::REG_INDEX:    index_idx <= pwdata[mmu_pkg::TLB_IDX_W-1:0];
                    cp0_regmap_pkg::REG_ENTRYLO0: entrylo0  <= lo_wr;
                    cp0_regmap_pkg::REG_ENTRYLO1: entrylo1  <= lo_wr;
                    cp0_regmap_pkg::REG_ENTRYHI:  entryhi   <= hi_wr;
                    default: ;
                endcase
            end
            if (do_tlbp) begin
                index_p <= !probe.hit;       // P is only set by tlbp
                if (probe.hit) begin
                    index_idx <= probe.idx;
                end
            end
        end
    end

    assign probe.vpn2 = entryhi.hi.vpn2;
    assign probe.asid = entryhi.hi.asid;
    assign probe.odd  = 1'b0;    // probe needs the match only

    assign tlb_widx = index_idx;
    assign asid     = entryhi.hi.asid;

    always_comb begin
        tlb_wentry.vpn2 = entryhi.hi.vpn2;
        tlb_wentry.asid = entryhi.hi.asid;
        tlb_wentry.g    = entrylo0.lo.g & entrylo1.lo.g;
        tlb_wentry.p0   = {entrylo0.lo.pfn, entrylo0.lo.c, entrylo0.lo.d, entrylo0.lo.v};
        tlb_wentry.p1   = {entrylo1.lo.pfn, entrylo1.lo.c, entrylo1.lo.d, entrylo1.lo.v};
    end

    // a command needs a full setup then access sequence
    cmd_after_setup: assert property (@(posedge aclk) disable iff (!rst_n)
        (tlb_we || do_tlbp) |-> $past(psel && !penable));

endmodule

/* verilog/tlb_array.sv */
`timescale 1ns/1ps
// fully associative dual-page tlb storage
// indexed write port for tlbwi
// three parallel match ports for fetch, data and probe
module tlb_array (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] widx,
    input  mmu_pkg::tlb_entry_t           wentry,
    tlb_search_if.array                   s_inst,
    tlb_search_if.array                   s_data,
    tlb_search_if.array                   s_probe
);

    mmu_pkg::tlb_entry_t             entries [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_ENTRIES-1:0] used;   // written since reset
    logic [mmu_pkg::TLB_ENTRIES-1:0] m_inst, m_data, m_probe;

    function automatic logic [mmu_pkg::TLB_ENTRIES-1:0] match_vec(
        input mmu_pkg::tlb_entry_t             ents [mmu_pkg::TLB_ENTRIES],
        input logic [mmu_pkg::TLB_ENTRIES-1:0] en,
        input logic [mmu_pkg::VPN2_W-1:0]      vpn2,
        input logic [mmu_pkg::ASID_W-1:0]      asid
    );
        logic [mmu_pkg::TLB_ENTRIES-1:0] m;
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            m[i] = en[i] && (ents[i].vpn2 == vpn2) && (ents[i].g || ents[i].asid == asid);
        end
        return m;
    endfunction

    function automatic mmu_pkg::page_info_t pick_page(
        input mmu_pkg::tlb_entry_t             ents [mmu_pkg::TLB_ENTRIES],
        input logic [mmu_pkg::TLB_ENTRIES-1:0] m,
        input logic                            odd
    );
        mmu_pkg::page_info_t p;
        p = '0;
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            if (m[i]) begin
                p = odd ? ents[i].p1 : ents[i].p0;
            end
        end
        return p;
    endfunction

    function automatic logic [mmu_pkg::TLB_IDX_W-1:0] encode(
        input logic [mmu_pkg::TLB_ENTRIES-1:0] m
    );
        logic [mmu_pkg::TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            if (m[i]) begin
                idx = i[mmu_pkg::TLB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            used <= '0;
        end else if (we) begin
            used[widx] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            entries[widx] <= wentry;
        end
    end

    assign m_inst       = match_vec(entries, used, s_inst.vpn2, s_inst.asid);
    assign s_inst.hit   = |m_inst;
    assign s_inst.idx   = encode(m_inst);
    assign s_inst.page  = pick_page(entries, m_inst, s_inst.odd);

    assign m_data       = match_vec(entries, used, s_data.vpn2, s_data.asid);
    assign s_data.hit   = |m_data;
    assign s_data.idx   = encode(m_data);
    assign s_data.page  = pick_page(entries, m_data, s_data.odd);

    assign m_probe      = match_vec(entries, used, s_probe.vpn2, s_probe.asid);
    assign s_probe.hit  = |m_probe;
    assign s_probe.idx  = encode(m_probe);
    assign s_probe.page = pick_page(entries, m_probe, s_probe.odd);

    // software must never leave two entries mapping the same page
    single_match: assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(m_inst) && $onehot0(m_data) && $onehot0(m_probe));

endmodule

/* verilog/tlb_buffer.sv */
`timescale 1ns/1ps
// one-entry translation buffer for a fetch or data port
// kseg0/kseg1 decode, one-cycle refill from the tlb array
// refill, invalid and modified exception coding
module tlb_buffer #(
    parameter bit IS_DATA = 1'b0    // data port can raise modified
) (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic [mmu_pkg::ASID_W-1:0] asid,
    input  logic                       req,
    input  logic [31:0]                vaddr,
    input  logic                       store,
    output logic [31:0]                paddr,
    output logic                       ready,
    output logic                       cached,
    output mmu_pkg::tlb_exc_e          excode,
    tlb_search_if.requester            search
);

    logic [2:0]                 seg;
    logic                       unmapped;
    logic                       tag_hit;
    logic                       load;
    logic                       buf_valid;
    logic [mmu_pkg::VPN2_W-1:0] buf_vpn2;
    logic                       buf_odd;
    logic [mmu_pkg::ASID_W-1:0] buf_asid;
    logic                       buf_hit;    // array hit when loaded
    mmu_pkg::page_info_t        buf_page;

    assign seg      = vaddr[31:29];
    assign unmapped = (seg == mmu_pkg::SEG_KSEG0) || (seg == mmu_pkg::SEG_KSEG1);
    assign tag_hit  = buf_valid && (buf_vpn2 == vaddr[31:13]) && (buf_odd == vaddr[12])
                      && (buf_asid == asid);
    assign load     = req && !unmapped && !tag_hit;
    assign ready    = !load;                // stall only while loading

    assign search.vpn2 = vaddr[31:13];
    assign search.odd  = vaddr[12];
    assign search.asid = asid;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (flush) begin
            buf_valid <= 1'b0;              // tlb contents changed
        end else if (load) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            buf_vpn2 <= vaddr[31:13];
            buf_odd  <= vaddr[12];
            buf_asid <= asid;
            buf_hit  <= search.hit;         // a miss is buffered too
            buf_page <= search.page;
        end
    end

    always_comb begin
        if (unmapped) begin
            paddr  = {3'b000, vaddr[28:0]};
            cached = (seg == mmu_pkg::SEG_KSEG0);
        end else begin
            paddr  = {buf_page.pfn, vaddr[11:0]};
            cached = (buf_page.c == mmu_pkg::CACHED_C);
        end
    end

    always_comb begin
        excode = mmu_pkg::EXC_NONE;
        if (req && !unmapped && tag_hit) begin
            if (!buf_hit) begin
                excode = mmu_pkg::EXC_REFILL;
            end else if (!buf_page.v) begin
                excode = mmu_pkg::EXC_INVALID;
            end else if (IS_DATA && store && !buf_page.d) begin
                excode = mmu_pkg::EXC_MODIFIED;
            end
        end
    end

    // a held request finishes right after its load cycle
    one_stall: assert property (@(posedge aclk) disable iff (!rst_n)
        (!ready && !flush) |=> (ready || $changed(asid)));

endmodule

/* verilog/tlb_mmu.sv */
`timescale 1ns/1ps
// mmu top level
// apb cp0 registers, tlb array and the fetch and data translation buffers
module tlb_mmu (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              i_req,
    input  logic [31:0]       i_vaddr,
    output logic [31:0]       i_paddr,
    output logic              i_ready,
    output logic              i_cached,
    output mmu_pkg::tlb_exc_e i_excode,
    input  logic              d_req,
    input  logic [31:0]       d_vaddr,
    input  logic              d_store,
    output logic [31:0]       d_paddr,
    output logic              d_ready,
    output logic              d_cached,
    output mmu_pkg::tlb_exc_e d_excode
);

    logic                          tlb_we;       // also flushes both buffers
    logic [mmu_pkg::TLB_IDX_W-1:0] tlb_widx;
    mmu_pkg::tlb_entry_t           tlb_wentry;
    logic [mmu_pkg::ASID_W-1:0]    asid;

    tlb_search_if s_inst ();
    tlb_search_if s_data ();
    tlb_search_if s_probe ();

    tlb_cp0_regs u_cp0_regs (
        .*,
        .probe      (s_probe)
    );

    tlb_array u_tlb_array (
        .*,
        .we         (tlb_we),
        .widx       (tlb_widx),
        .wentry     (tlb_wentry)
    );

    tlb_buffer #(.IS_DATA(1'b0)) u_ibuf (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .flush      (tlb_we),
        .asid       (asid),
        .req        (i_req),
        .vaddr      (i_vaddr),
        .store      (1'b0),          // fetches never store
        .paddr      (i_paddr),
        .ready      (i_ready),
        .cached     (i_cached),
        .excode     (i_excode),
        .search     (s_inst)
    );

    tlb_buffer #(.IS_DATA(1'b1)) u_dbuf (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .flush      (tlb_we),
        .asid       (asid),
        .req        (d_req),
        .vaddr      (d_vaddr),
        .store      (d_store),
        .paddr      (d_paddr),
        .ready      (d_ready),
        .cached     (d_cached),
        .excode     (d_excode),
        .search     (s_data)
    );

endmodule

/* test/tb_tlb_mmu.sv */
`timescale 1ns/1ps
// testbench for the tlb mmu
// reference tlb model that mirrors every tlbwi
// apb and translation request tasks, concurrent output checks
// watchdog and per-test report
module tb_tlb_mmu;

    localparam int CLK_HALF_NS   = 2;    // 4 ns period
    localparam int RESET_CYCLES  = 5;
    localparam int TEST_CYCLES   = 50 + 40 + 260 + 110 + 40 + 50;   // one estimate per test
    localparam int MARGIN_CYCLES = 200;
    localparam int MAX_STALL     = 4;
    localparam logic [7:0] ASID_A = 8'h3c;

    typedef struct packed {
        logic [31:0]       paddr;
        logic              cached;
        mmu_pkg::tlb_exc_e exc;
    } ref_result_t;

    logic              aclk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [7:0]        paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              i_req;
    logic [31:0]       i_vaddr;
    logic [31:0]       i_paddr;
    logic              i_ready;
    logic              i_cached;
    mmu_pkg::tlb_exc_e i_excode;
    logic              d_req;
    logic [31:0]       d_vaddr;
    logic              d_store;
    logic [31:0]       d_paddr;
    logic              d_ready;
    logic              d_cached;
    mmu_pkg::tlb_exc_e d_excode;

    mmu_pkg::tlb_entry_t m_ent [mmu_pkg::TLB_ENTRIES];   // reference tlb
    logic [mmu_pkg::TLB_ENTRIES-1:0] m_used;
    logic [7:0]          cur_asid;                      // mirrors entryhi asid
    ref_result_t         i_exp;
    ref_result_t         d_exp;
    logic [31:0]         rng_state;
    int                  err_count;
    int                  test_err_start;
    int                  ok_count;
    int                  bad_count;

    tlb_mmu i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF_NS aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // expected translation from the reference tlb
    function automatic ref_result_t ref_translate(
        input logic [31:0] va,
        input logic        st,
        input logic        is_data
    );
        ref_result_t         r;
        mmu_pkg::page_info_t pg;
        logic                hit;
        pg  = '0;
        hit = 1'b0;
        if (va[31:29] == mmu_pkg::SEG_KSEG0 || va[31:29] == mmu_pkg::SEG_KSEG1) begin
            r.paddr  = va & 32'h1fff_ffff;
            r.cached = (va[31:29] == mmu_pkg::SEG_KSEG0);
            r.exc    = mmu_pkg::EXC_NONE;
            return r;
        end
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            if (m_used[i] && m_ent[i].vpn2 == va[31:13]
                && (m_ent[i].g || m_ent[i].asid == cur_asid)) begin
                hit = 1'b1;
                pg  = va[12] ? m_ent[i].p1 : m_ent[i].p0;
            end
        end
        if (!hit) begin
            r.exc = mmu_pkg::EXC_REFILL;
        end else if (!pg.v) begin
            r.exc = mmu_pkg::EXC_INVALID;
        end else if (is_data && st && !pg.d) begin
            r.exc = mmu_pkg::EXC_MODIFIED;
        end else begin
            r.exc = mmu_pkg::EXC_NONE;
        end
        r.paddr  = {pg.pfn, va[11:0]};
        r.cached = (pg.c == mmu_pkg::CACHED_C);
        return r;
    endfunction

    function automatic logic apb_mapped(input logic [7:0] a);
        return a == cp0_regmap_pkg::REG_INDEX || a == cp0_regmap_pkg::REG_ENTRYLO0
            || a == cp0_regmap_pkg::REG_ENTRYLO1 || a == cp0_regmap_pkg::REG_ENTRYHI
            || a == cp0_regmap_pkg::REG_CMD;
    endfunction

    function automatic logic [31:0] lo_word(input mmu_pkg::page_info_t p, input logic g);
        cp0_regmap_pkg::cp0_word_u w;
        w        = '0;
        w.lo.pfn = p.pfn;
        w.lo.c   = p.c;
        w.lo.d   = p.d;
        w.lo.v   = p.v;
        w.lo.g   = g;
        return w;
    endfunction

    function automatic logic [31:0] hi_word(input logic [18:0] vpn2, input logic [7:0] asid);
        cp0_regmap_pkg::cp0_word_u w;
        w         = '0;
        w.hi.vpn2 = vpn2;
        w.hi.asid = asid;
        return w;
    endfunction

    // vpn2 carries the index in bits 15:13, so entries never overlap
    function automatic mmu_pkg::tlb_entry_t rand_entry(input int idx);
        mmu_pkg::tlb_entry_t e;
        logic [31:0]         r0;
        logic [31:0]         r1;
        logic [31:0]         r2;
        r0     = xorshift32();
        r1     = xorshift32();
        r2     = xorshift32();
        e.vpn2 = {(r0[0] ? 3'b110 : 3'b000), idx[2:0], r0[20:8]};
        e.asid = ASID_A;
        e.g    = 1'b0;
        e.p0   = {r1[19:0], (r1[20] ? mmu_pkg::CACHED_C : 3'd2), 1'b1, 1'b1};
        e.p1   = {r2[19:0], (r2[20] ? mmu_pkg::CACHED_C : 3'd2), 1'b1, 1'b1};
        return e;
    endfunction

    function automatic logic [31:0] va_of(input mmu_pkg::tlb_entry_t e, input logic odd);
        logic [31:0] r;
        r = xorshift32();
        return {e.vpn2, odd, r[11:0]};
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic fail_note(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        word_ok: assert (got === exp) else mismatch(name, got, exp);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge aclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge aclk);
        penable <= 1'b1;
        @(posedge aclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        if (addr == cp0_regmap_pkg::REG_ENTRYHI) begin
            cur_asid = data[7:0];
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge aclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge aclk);
        penable <= 1'b1;
        @(posedge aclk);
        data = prdata;    // access cycle value
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic tlb_write(input int idx, input mmu_pkg::tlb_entry_t e);
        apb_write(cp0_regmap_pkg::REG_INDEX, 32'(idx));
        apb_write(cp0_regmap_pkg::REG_ENTRYLO0, lo_word(e.p0, e.g));
        apb_write(cp0_regmap_pkg::REG_ENTRYLO1, lo_word(e.p1, e.g));
        apb_write(cp0_regmap_pkg::REG_ENTRYHI, hi_word(e.vpn2, e.asid));
        apb_write(cp0_regmap_pkg::REG_CMD, cp0_regmap_pkg::CMD_TLBWI);
        m_ent[idx]  = e;
        m_used[idx] = 1'b1;
    endtask

    // holds the request until ready, then checks the stall count
    task automatic do_req(input logic is_data, input logic [31:0] va, input logic st,
                          input int exp_lat);
        int   lat;
        logic rdy;
        @(posedge aclk);
        if (is_data) begin
            d_req   <= 1'b1;
            d_vaddr <= va;
            d_store <= st;
        end else begin
            i_req   <= 1'b1;
            i_vaddr <= va;
        end
        lat = 0;
        @(posedge aclk);
        rdy = is_data ? d_ready : i_ready;
        while (!rdy && lat < MAX_STALL) begin
            lat++;
            @(posedge aclk);
            rdy = is_data ? d_ready : i_ready;
        end
        if (!rdy) begin
            fail_note("translation request never saw ready");
        end else begin
            latency_ok: assert (lat == exp_lat)
                else mismatch(is_data ? "d_ready latency" : "i_ready latency", lat, exp_lat);
        end
        i_req   <= 1'b0;
        d_req   <= 1'b0;
        d_store <= 1'b0;
    endtask

    task automatic begin_test();
        test_err_start = err_count;
    endtask

    task automatic end_test(input string name);
        @(posedge aclk);    // let checks of the last cycle report
        if (err_count == test_err_start) begin
            ok_count++;
            $display("test %s: ok", name);
        end else begin
            bad_count++;
            $display("test %s: FAIL, %0d errors", name, err_count - test_err_start);
        end
    endtask

    always_comb begin
        i_exp = ref_translate(i_vaddr, 1'b0, 1'b0);
        d_exp = ref_translate(d_vaddr, d_store, 1'b1);
    end

    i_exc_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (i_req && i_ready) |-> i_excode == i_exp.exc)
        else mismatch("i_excode", $sampled(i_excode), $sampled(i_exp.exc));
    i_paddr_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (i_req && i_ready && i_exp.exc == mmu_pkg::EXC_NONE) |-> i_paddr == i_exp.paddr)
        else mismatch("i_paddr", $sampled(i_paddr), $sampled(i_exp.paddr));
    i_cached_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (i_req && i_ready && i_exp.exc == mmu_pkg::EXC_NONE) |-> i_cached == i_exp.cached)
        else mismatch("i_cached", $sampled(i_cached), $sampled(i_exp.cached));
    d_exc_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (d_req && d_ready) |-> d_excode == d_exp.exc)
        else mismatch("d_excode", $sampled(d_excode), $sampled(d_exp.exc));
    d_paddr_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (d_req && d_ready && d_exp.exc == mmu_pkg::EXC_NONE) |-> d_paddr == d_exp.paddr)
        else mismatch("d_paddr", $sampled(d_paddr), $sampled(d_exp.paddr));
    d_cached_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (d_req && d_ready && d_exp.exc == mmu_pkg::EXC_NONE) |-> d_cached == d_exp.cached)
        else mismatch("d_cached", $sampled(d_cached), $sampled(d_exp.cached));

    // idle ports stay ready with no exception
    i_idle_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        !i_req |-> (i_ready && i_excode == mmu_pkg::EXC_NONE))
        else fail_note("instruction port not ready or raising an exception while idle");
    d_idle_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        !d_req |-> (d_ready && d_excode == mmu_pkg::EXC_NONE))
        else fail_note("data port not ready or raising an exception while idle");
    i_stall_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (i_req && !i_ready) |=> i_ready)
        else fail_note("instruction port stalled for more than one cycle");
    d_stall_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        (d_req && !d_ready) |=> d_ready)
        else fail_note("data port stalled for more than one cycle");

    pready_chk: assert property (@(posedge aclk) disable iff (!rst_n) pready)
        else fail_note("pready went low");
    pslverr_chk: assert property (@(posedge aclk) disable iff (!rst_n)
        pslverr == (psel && penable && !apb_mapped(paddr)))
        else mismatch("pslverr", $sampled(pslverr), $sampled(psel && penable && !apb_mapped(paddr)));

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF_NS);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0]         r;
        logic [31:0]         rd;
        logic [31:0]         va;
        mmu_pkg::tlb_entry_t e;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        i_req     = 1'b0;
        i_vaddr   = '0;
        d_req     = 1'b0;
        d_vaddr   = '0;
        d_store   = 1'b0;
        rng_state = 32'hcba1;
        m_used    = '0;
        cur_asid  = '0;
        err_count = 0;
        ok_count  = 0;
        bad_count = 0;
        rst_n     = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;

        begin_test();
        apb_write(cp0_regmap_pkg::REG_INDEX, 32'hffff_fffd);
        apb_read(cp0_regmap_pkg::REG_INDEX, rd);
        check_word("index", rd, 32'h5);          // P clear since reset
        r = xorshift32();
        apb_write(cp0_regmap_pkg::REG_ENTRYLO0, r);
        apb_read(cp0_regmap_pkg::REG_ENTRYLO0, rd);
        check_word("entrylo0", rd, r & 32'h03ff_ffff);
        r = xorshift32();
        apb_write(cp0_regmap_pkg::REG_ENTRYLO1, r);
        apb_read(cp0_regmap_pkg::REG_ENTRYLO1, rd);
        check_word("entrylo1", rd, r & 32'h03ff_ffff);
        r = xorshift32();
        apb_write(cp0_regmap_pkg::REG_ENTRYHI, r);
        apb_read(cp0_regmap_pkg::REG_ENTRYHI, rd);
        check_word("entryhi", rd, r & 32'hffff_e0ff);
        apb_read(8'h14, rd);                     // unmapped, pslverr expected
        apb_write(8'h20, 32'hdead_beef);
        end_test("apb register access");

        begin_test();
        for (int k = 0; k < 2; k++) begin
            r = xorshift32();
            do_req(1'b0, {mmu_pkg::SEG_KSEG0, r[28:0]}, 1'b0, 0);
            do_req(1'b1, {mmu_pkg::SEG_KSEG1, r[31:3]}, r[0], 0);
            r = xorshift32();
            do_req(1'b0, {mmu_pkg::SEG_KSEG1, r[28:0]}, 1'b0, 0);
            do_req(1'b1, {mmu_pkg::SEG_KSEG0, r[31:3]}, r[0], 0);
        end
        end_test("unmapped segments");

        begin_test();
        for (int k = 0; k < mmu_pkg::TLB_ENTRIES; k++) begin
            tlb_write(k, rand_entry(k));
        end
        for (int k = 0; k < mmu_pkg::TLB_ENTRIES; k++) begin
            va = va_of(m_ent[k], 1'b0);
            do_req(1'b0, va, 1'b0, 1);
            do_req(1'b0, va, 1'b0, 0);           // buffered
            va = va_of(m_ent[k], 1'b1);
            r  = xorshift32();
            do_req(1'b1, va, r[0], 1);
            do_req(1'b1, va, r[1], 0);
        end
        end_test("mapped translation");

        begin_test();
        r  = xorshift32();
        va = {3'b010, r[28:0]};                   // no entry maps this region
        do_req(1'b0, va, 1'b0, 1);
        do_req(1'b0, va, 1'b0, 0);                // buffered miss
        do_req(1'b1, va, 1'b1, 1);
        e      = m_ent[0];
        e.p0.v = 1'b0;
        e.p1.d = 1'b0;
        tlb_write(0, e);
        do_req(1'b1, va_of(e, 1'b0), 1'b0, 1);    // invalid
        va = va_of(e, 1'b1);
        do_req(1'b1, va, 1'b1, 1);                // modified
        do_req(1'b1, va, 1'b0, 0);
        do_req(1'b0, va, 1'b0, 1);                // fetch ignores d
        e      = m_ent[1];
        e.g    = 1'b1;
        e.asid = 8'h11;
        tlb_write(1, e);
        apb_write(cp0_regmap_pkg::REG_ENTRYHI, hi_word('0, 8'h77));
        do_req(1'b1, va_of(e, 1'b0), 1'b0, 1);    // global hit
        do_req(1'b1, va_of(m_ent[2], 1'b0), 1'b0, 1);
        do_req(1'b0, va_of(m_ent[2], 1'b1), 1'b0, 1);
        end_test("tlb exceptions");

        begin_test();
        r = xorshift32();
        apb_write(cp0_regmap_pkg::REG_ENTRYHI, hi_word({3'b010, r[15:0]}, ASID_A));
        apb_write(cp0_regmap_pkg::REG_CMD, cp0_regmap_pkg::CMD_TLBP);
        apb_read(cp0_regmap_pkg::REG_INDEX, rd);
        check_word("index P bit after miss probe", {31'd0, rd[31]}, 32'h1);
        apb_write(cp0_regmap_pkg::REG_ENTRYHI, hi_word(m_ent[4].vpn2, ASID_A));
        apb_write(cp0_regmap_pkg::REG_CMD, cp0_regmap_pkg::CMD_TLBP);
        apb_read(cp0_regmap_pkg::REG_INDEX, rd);
        check_word("index after hit probe", rd, 32'h4);   // P cleared by the hit
        end_test("tlb probe");

        begin_test();
        va = va_of(m_ent[5], 1'b0);
        do_req(1'b1, va, 1'b0, 1);
        do_req(1'b1, va, 1'b0, 0);
        e        = m_ent[5];
        e.p0.pfn = ~e.p0.pfn;
        tlb_write(5, e);                          // also flushes both buffers
        do_req(1'b1, va, 1'b0, 1);
        do_req(1'b1, va, 1'b0, 0);
        end_test("rewrite of a buffered entry");

        $display("tests: %0d ok, %0d failing, %0d errors", ok_count, bad_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tlb_mmu.f */
verilog/mmu_pkg.sv
verilog/cp0_regmap_pkg.sv
verilog/tlb_search_if.sv
verilog/tlb_cp0_regs.sv
verilog/tlb_array.sv
verilog/tlb_buffer.sv
verilog/tlb_mmu.sv
test/tb_tlb_mmu.sv
